// ==== logic/gnn_pkg.sv ====
`default_nettype none

package gnn_pkg;

    //////////////////////////////////////////////////////////////////////
    // Feature stream geometry
    //////////////////////////////////////////////////////////////////////

    localparam int FV_SIZE     = 16;                    // Signed feature or weight.
    localparam int FV_PER_LINE = 4;                     // Features per bank line.
    localparam int MAX_FV_NUM  = 16;                    // Features per node vector.
    localparam int FV_IDX_W    = $clog2(MAX_FV_NUM);

    //////////////////////////////////////////////////////////////////////
    // Batch and PE array sizing
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_RS_SLOTS = 4;                    // Nodes per batch, one per lane.
    localparam int MULT_PER_PE  = 4;                    // Window width.
    localparam int MAX_NODE_ID  = 256;
    localparam int NODE_ID_W    = $clog2(MAX_NODE_ID);
    localparam int ACC_W        = 40;                   // Dot product accumulator.

endpackage

`default_nettype wire

// ==== logic/vertex_rs.sv ====
`timescale 1ns/100ps
`default_nettype none

module vertex_rs
    import gnn_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   bank_sos,
    input  wire                   bank_eos,
    input  wire  [FV_SIZE-1:0]    bank_fv_0,
    input  wire  [FV_SIZE-1:0]    bank_fv_1,
    input  wire  [FV_SIZE-1:0]    bank_fv_2,
    input  wire  [FV_SIZE-1:0]    bank_fv_3,
    input  wire  [NODE_ID_W-1:0]  bank_node_id,
    input  wire  [FV_IDX_W-1:0]   start_idx,
    input  wire                   complete,
    input  wire                   vertex_buf_idle,
    output logic [FV_SIZE-1:0]    win_0_0, win_0_1, win_0_2, win_0_3,
    output logic [FV_SIZE-1:0]    win_1_0, win_1_1, win_1_2, win_1_3,
    output logic [FV_SIZE-1:0]    win_2_0, win_2_1, win_2_2, win_2_3,
    output logic [FV_SIZE-1:0]    win_3_0, win_3_1, win_3_2, win_3_3,
    output logic [NODE_ID_W-1:0]  node_id_0, node_id_1, node_id_2, node_id_3,
    output logic                  fire,
    output logic                  rs_available,
    output logic                  rs_empty
);

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_receive     = 3'd1,
        st_wait_vertex = 3'd2,
        st_wait_buffer = 3'd3
    } state_t;

    state_t                                               state;
    logic [NUM_RS_SLOTS-1:0][MAX_FV_NUM-1:0][FV_SIZE-1:0]  fv_data;
    logic [NUM_RS_SLOTS-1:0][NODE_ID_W-1:0]                slot_node_id;
    logic [NUM_RS_SLOTS-1:0][MULT_PER_PE-1:0][FV_SIZE-1:0] win_q;
    logic [NUM_RS_SLOTS-1:0][NODE_ID_W-1:0]                node_id_q;
    logic [FV_PER_LINE-1:0][FV_SIZE-1:0]                   line;
    logic [$clog2(NUM_RS_SLOTS):0]                         rs_cnt;
    logic [$clog2(NUM_RS_SLOTS)-1:0]                       rs_ptr;
    logic [FV_IDX_W-1:0]                                   num_fv;
    logic                                                  line_we;
    logic                                                  release_batch;

    assign line    = {bank_fv_3, bank_fv_2, bank_fv_1, bank_fv_0};
    assign line_we = (state == st_idle && bank_sos) || state == st_receive;

    // Fourth stream ends in this cycle.
    assign fire = state == st_receive && bank_eos && rs_cnt == NUM_RS_SLOTS;

    assign rs_available = state == st_idle;
    assign rs_empty     = rs_cnt == '0;

    // Buffer drained, or the FSM left its legal states.
    assign release_batch = (state == st_wait_buffer && vertex_buf_idle) ||
                           state > st_wait_buffer;

    //////////////////////////////////////////////////////////////////////
    // Slot storage and FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            rs_cnt       <= '0;
            rs_ptr       <= '0;
            num_fv       <= '0;
            fv_data      <= '0;
            slot_node_id <= '0;
            win_q        <= '0;
            node_id_q    <= '0;
        end else begin
            if (line_we) begin
                for (int j = 0; j < FV_PER_LINE; j++) begin
                    fv_data[rs_ptr][num_fv + FV_IDX_W'(j)] <= line[j];
                end
            end

            case (state)
                st_idle: begin
                    if (bank_sos) begin
                        slot_node_id[rs_ptr] <= bank_node_id;
                        rs_cnt               <= rs_cnt + 1'b1;
                        num_fv               <= num_fv + FV_IDX_W'(FV_PER_LINE);
                        state                <= st_receive;
                    end
                end
                st_receive: begin
                    if (bank_eos) begin
                        num_fv <= '0;
                        if (fire) begin
                            rs_ptr <= '0;
                            state  <= st_wait_vertex;
                        end else begin
                            rs_ptr <= rs_ptr + 1'b1;  // Next slot.
                            state  <= st_idle;
                        end
                    end else begin
                        num_fv <= num_fv + FV_IDX_W'(FV_PER_LINE);
                    end
                end
                st_wait_vertex: begin
                    for (int k = 0; k < NUM_RS_SLOTS; k++) begin
                        for (int j = 0; j < MULT_PER_PE; j++) begin
                            win_q[k][j] <= fv_data[k][start_idx + FV_IDX_W'(j)];
                        end
                    end
                    node_id_q <= slot_node_id;
                    if (complete) begin
                        state <= st_wait_buffer;
                    end
                end
                st_wait_buffer: begin
                    if (vertex_buf_idle) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            // Zeroed slots make short streams read as zeros next batch.
            if (release_batch) begin
                rs_cnt       <= '0;
                rs_ptr       <= '0;
                num_fv       <= '0;
                fv_data      <= '0;
                slot_node_id <= '0;
                win_q        <= '0;
                node_id_q    <= '0;
            end
        end
    end

    assign {win_0_3, win_0_2, win_0_1, win_0_0} = win_q[0];
    assign {win_1_3, win_1_2, win_1_1, win_1_0} = win_q[1];
    assign {win_2_3, win_2_2, win_2_1, win_2_0} = win_q[2];
    assign {win_3_3, win_3_2, win_3_1, win_3_0} = win_q[3];
    assign {node_id_3, node_id_2, node_id_1, node_id_0} = node_id_q;

endmodule

`default_nettype wire

// ==== logic/weight_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module weight_bank
    import gnn_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 weight_we,
    input  wire  [FV_IDX_W-1:0] weight_addr,
    input  wire  [FV_SIZE-1:0]  weight_data,
    input  wire  [FV_IDX_W-1:0] start_idx,
    output logic [FV_SIZE-1:0]  w_0,
    output logic [FV_SIZE-1:0]  w_1,
    output logic [FV_SIZE-1:0]  w_2,
    output logic [FV_SIZE-1:0]  w_3
);

    logic [MAX_FV_NUM-1:0][FV_SIZE-1:0]  weights;
    logic [MULT_PER_PE-1:0][FV_SIZE-1:0] w_win;

    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
            w_win   <= '0;
        end else begin
            if (weight_we) begin
                weights[weight_addr] <= weight_data;
            end
            // Same latency as the station window.
            for (int j = 0; j < MULT_PER_PE; j++) begin
                w_win[j] <= weights[start_idx + FV_IDX_W'(j)];
            end
        end
    end

    assign {w_3, w_2, w_1, w_0} = w_win;

endmodule

`default_nettype wire

// ==== logic/vertex_pe.sv ====
`timescale 1ns/100ps
`default_nettype none

module vertex_pe
    import gnn_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       clear,
    input  wire                       acc_en,
    input  wire  signed [FV_SIZE-1:0] fv_0,
    input  wire  signed [FV_SIZE-1:0] fv_1,
    input  wire  signed [FV_SIZE-1:0] fv_2,
    input  wire  signed [FV_SIZE-1:0] fv_3,
    input  wire  signed [FV_SIZE-1:0] w_0,
    input  wire  signed [FV_SIZE-1:0] w_1,
    input  wire  signed [FV_SIZE-1:0] w_2,
    input  wire  signed [FV_SIZE-1:0] w_3,
    output logic signed [ACC_W-1:0]   acc
);

    logic signed [2*FV_SIZE-1:0] prod [MULT_PER_PE];
    logic signed [ACC_W-1:0]     sum_lo;
    logic signed [ACC_W-1:0]     sum_hi;
    logic signed [ACC_W-1:0]     sum;

    assign prod[0] = fv_0 * w_0;
    assign prod[1] = fv_1 * w_1;
    assign prod[2] = fv_2 * w_2;
    assign prod[3] = fv_3 * w_3;

    // Two level adder tree.
    assign sum_lo = ACC_W'(prod[0]) + ACC_W'(prod[1]);
    assign sum_hi = ACC_W'(prod[2]) + ACC_W'(prod[3]);
    assign sum    = sum_lo + sum_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (acc_en) begin
            acc <= acc + sum;
        end
    end

endmodule

`default_nettype wire

// ==== logic/vertex_pe_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module vertex_pe_array
    import gnn_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      fire,
    input  wire  [FV_SIZE-1:0]       win_0_0, win_0_1, win_0_2, win_0_3,
    input  wire  [FV_SIZE-1:0]       win_1_0, win_1_1, win_1_2, win_1_3,
    input  wire  [FV_SIZE-1:0]       win_2_0, win_2_1, win_2_2, win_2_3,
    input  wire  [FV_SIZE-1:0]       win_3_0, win_3_1, win_3_2, win_3_3,
    input  wire  [NODE_ID_W-1:0]     node_id_0, node_id_1, node_id_2, node_id_3,
    input  wire  [FV_SIZE-1:0]       w_0,
    input  wire  [FV_SIZE-1:0]       w_1,
    input  wire  [FV_SIZE-1:0]       w_2,
    input  wire  [FV_SIZE-1:0]       w_3,
    output logic [FV_IDX_W-1:0]      start_idx,
    output logic                     complete,
    output logic                     result_valid,
    output logic signed [ACC_W-1:0]  result_0,
    output logic signed [ACC_W-1:0]  result_1,
    output logic signed [ACC_W-1:0]  result_2,
    output logic signed [ACC_W-1:0]  result_3,
    output logic [NODE_ID_W-1:0]     result_node_id_0,
    output logic [NODE_ID_W-1:0]     result_node_id_1,
    output logic [NODE_ID_W-1:0]     result_node_id_2,
    output logic [NODE_ID_W-1:0]     result_node_id_3
);

    logic [NUM_RS_SLOTS-1:0][MULT_PER_PE-1:0][FV_SIZE-1:0] win;
    logic [NUM_RS_SLOTS-1:0][NODE_ID_W-1:0]                node_id;
    logic [MULT_PER_PE-1:0][FV_SIZE-1:0]                   w;
    logic [NUM_RS_SLOTS-1:0][ACC_W-1:0]                    acc;
    logic [NUM_RS_SLOTS-1:0][NODE_ID_W-1:0]                result_node_id;
    logic                                                  issuing;
    logic                                                  acc_en;
    logic                                                  last_win;
    logic                                                  done;

    assign win[0]  = {win_0_3, win_0_2, win_0_1, win_0_0};
    assign win[1]  = {win_1_3, win_1_2, win_1_1, win_1_0};
    assign win[2]  = {win_2_3, win_2_2, win_2_1, win_2_0};
    assign win[3]  = {win_3_3, win_3_2, win_3_1, win_3_0};
    assign node_id = {node_id_3, node_id_2, node_id_1, node_id_0};
    assign w       = {w_3, w_2, w_1, w_0};

    assign last_win = acc_en && !issuing;  // Final window in this cycle.

    //////////////////////////////////////////////////////////////////////
    // Window sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing        <= 1'b0;
            start_idx      <= '0;
            acc_en         <= 1'b0;
            done           <= 1'b0;
            result_node_id <= '0;
        end else begin
            acc_en <= issuing;  // Window returns one cycle later.
            done   <= last_win;
            if (fire) begin
                issuing   <= 1'b1;
                start_idx <= '0;
            end else if (issuing) begin
                start_idx <= start_idx + FV_IDX_W'(MULT_PER_PE);
                if (start_idx == FV_IDX_W'(MAX_FV_NUM - MULT_PER_PE)) begin
                    issuing <= 1'b0;
                end
            end
            if (last_win) begin
                result_node_id <= node_id;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lanes, one node each
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_RS_SLOTS; k++) begin : g_lane
        vertex_pe u_pe (
            .clk    (clk),
            .reset  (reset),
            .clear  (fire),
            .acc_en (acc_en),
            .fv_0   (win[k][0]),
            .fv_1   (win[k][1]),
            .fv_2   (win[k][2]),
            .fv_3   (win[k][3]),
            .w_0    (w[0]),
            .w_1    (w[1]),
            .w_2    (w[2]),
            .w_3    (w[3]),
            .acc    (acc[k])
        );
    end

    // Accumulators hold their sums until the next fire.
    assign {result_3, result_2, result_1, result_0} = acc;
    assign {result_node_id_3, result_node_id_2, result_node_id_1, result_node_id_0} =
        result_node_id;

    assign complete     = done;
    assign result_valid = done;

endmodule

`default_nettype wire

// ==== logic/vertex_update_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vertex_update_top
    import gnn_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      bank_sos,
    input  wire                      bank_eos,
    input  wire  [FV_SIZE-1:0]       bank_fv_0,
    input  wire  [FV_SIZE-1:0]       bank_fv_1,
    input  wire  [FV_SIZE-1:0]       bank_fv_2,
    input  wire  [FV_SIZE-1:0]       bank_fv_3,
    input  wire  [NODE_ID_W-1:0]     bank_node_id,
    input  wire                      weight_we,
    input  wire  [FV_IDX_W-1:0]      weight_addr,
    input  wire  [FV_SIZE-1:0]       weight_data,
    input  wire                      vertex_buf_idle,
    output logic                     rs_available,
    output logic                     rs_empty,
    output logic                     result_valid,
    output logic signed [ACC_W-1:0]  result_0,
    output logic signed [ACC_W-1:0]  result_1,
    output logic signed [ACC_W-1:0]  result_2,
    output logic signed [ACC_W-1:0]  result_3,
    output logic [NODE_ID_W-1:0]     result_node_id_0,
    output logic [NODE_ID_W-1:0]     result_node_id_1,
    output logic [NODE_ID_W-1:0]     result_node_id_2,
    output logic [NODE_ID_W-1:0]     result_node_id_3
);

    //////////////////////////////////////////////////////////////////////
    // Station and weight windows into the PE array
    //////////////////////////////////////////////////////////////////////

    wire [FV_SIZE-1:0]   win_0_0, win_0_1, win_0_2, win_0_3;
    wire [FV_SIZE-1:0]   win_1_0, win_1_1, win_1_2, win_1_3;
    wire [FV_SIZE-1:0]   win_2_0, win_2_1, win_2_2, win_2_3;
    wire [FV_SIZE-1:0]   win_3_0, win_3_1, win_3_2, win_3_3;
    wire [NODE_ID_W-1:0] node_id_0, node_id_1, node_id_2, node_id_3;
    wire [FV_SIZE-1:0]   w_0, w_1, w_2, w_3;
    wire [FV_IDX_W-1:0]  start_idx;  // Shared by station and weight bank.
    wire                 fire;
    wire                 complete;

    vertex_rs u_rs (.*);

    weight_bank u_weight_bank (.*);

    vertex_pe_array u_pe_array (.*);

endmodule

`default_nettype wire

// ==== tests/tb_vertex_update.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vertex_update
    import gnn_pkg::*;
();

    localparam int WAIT_LIMIT  = 64;                    // Cycles per wait loop.
    localparam int WATCHDOG_NS = 2_000_000;

    logic                    clk;
    logic                    reset;
    logic                    bank_sos;
    logic                    bank_eos;
    logic [FV_SIZE-1:0]      bank_fv_0, bank_fv_1, bank_fv_2, bank_fv_3;
    logic [NODE_ID_W-1:0]    bank_node_id;
    logic                    weight_we;
    logic [FV_IDX_W-1:0]     weight_addr;
    logic [FV_SIZE-1:0]      weight_data;
    logic                    vertex_buf_idle;
    wire                     rs_available;
    wire                     rs_empty;
    wire                     result_valid;
    wire signed [ACC_W-1:0]  result_0, result_1, result_2, result_3;
    wire [NODE_ID_W-1:0]     result_node_id_0, result_node_id_1;
    wire [NODE_ID_W-1:0]     result_node_id_2, result_node_id_3;
    wire signed [ACC_W-1:0]  res [NUM_RS_SLOTS];
    wire [NODE_ID_W-1:0]     res_id [NUM_RS_SLOTS];

    // Reference model state.
    logic signed [FV_SIZE-1:0] feat [NUM_RS_SLOTS][MAX_FV_NUM];
    logic signed [FV_SIZE-1:0] w_model [MAX_FV_NUM];
    logic signed [ACC_W-1:0]   exp_res [NUM_RS_SLOTS];
    logic [NODE_ID_W-1:0]      exp_id [NUM_RS_SLOTS];
    int                        batch_len [NUM_RS_SLOTS];
    logic                      exp_valid;
    logic                      after_reset;
    logic                      stream_busy;         // Cycles after sos up to eos.
    logic                      batch_held;
    logic                      released;
    int                        cycle_cnt = 0;
    int                        eos_cycle;
    int                        errors = 0;
    int                        err_mark = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;

    vertex_update_top dut (.*);

    assign res[0]    = result_0;
    assign res[1]    = result_1;
    assign res[2]    = result_2;
    assign res[3]    = result_3;
    assign res_id[0] = result_node_id_0;
    assign res_id[1] = result_node_id_1;
    assign res_id[2] = result_node_id_2;
    assign res_id[3] = result_node_id_3;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        errors++;
    endtask

    assert property (@(posedge clk) disable iff (reset)
        after_reset |-> (rs_available && rs_empty && !result_valid))
    else report_error("station or array not idle after reset");

    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (exp_valid && cycle_cnt - eos_cycle == 6))
    else report_error($sformatf("result_valid %0d cycles after last eos",
                                cycle_cnt - eos_cycle));

    for (genvar k = 0; k < NUM_RS_SLOTS; k++) begin : g_lane_check
        assert property (@(posedge clk) disable iff (reset)
            result_valid |-> (res[k] == exp_res[k] && res_id[k] == exp_id[k]))
        else report_error($sformatf("lane %0d result %0d id %0d, expected %0d id %0d",
                                    k, res[k], res_id[k], exp_res[k], exp_id[k]));
    end

    assert property (@(posedge clk) disable iff (reset)
        bank_sos |=> (!rs_available && !rs_empty))
    else report_error("station available or empty after sos");

    assert property (@(posedge clk) disable iff (reset)
        (stream_busy || batch_held) |-> !rs_available)
    else report_error("rs_available high during a stream or a held batch");

    assert property (@(posedge clk) disable iff (reset)
        released |-> (rs_available && rs_empty))
    else report_error("batch not released after vertex_buf_idle");

    //////////////////////////////////////////////////////////////////////
    // Bank and weight drivers
    //////////////////////////////////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    function automatic logic signed [ACC_W-1:0] dot_product(input int slot);
        longint sum;
        sum = 0;
        for (int i = 0; i < MAX_FV_NUM; i++) begin
            sum += longint'(feat[slot][i]) * longint'(w_model[i]);
        end
        return ACC_W'(sum);
    endfunction

    task automatic wait_available();
        int n;
        n = 0;
        while (!rs_available && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!rs_available) begin
            $display("Timed out after %0d cycles waiting for rs_available", n);
            errors++;
        end
    endtask

    task automatic write_weights();
        for (int i = 0; i < MAX_FV_NUM; i++) begin
            w_model[i]  = FV_SIZE'($urandom);
            weight_we   = 1'b1;
            weight_addr = FV_IDX_W'(i);
            weight_data = w_model[i];
            tick();
        end
        weight_we = 1'b0;
    endtask

    task automatic send_stream(input int slot, input int lines, input logic [NODE_ID_W-1:0] id);
        wait_available();
        for (int i = 0; i < MAX_FV_NUM; i++) begin
            feat[slot][i] = (i < FV_PER_LINE * lines) ? FV_SIZE'($urandom) : '0;
        end
        exp_res[slot] = dot_product(slot);
        exp_id[slot]  = id;
        bank_node_id  = id;
        for (int k = 0; k < lines; k++) begin
            if (k > 0) begin
                tick();
                stream_busy = 1'b1;
            end
            bank_sos  = (k == 0);
            bank_eos  = (k == lines - 1);
            bank_fv_0 = feat[slot][4*k];
            bank_fv_1 = feat[slot][4*k+1];
            bank_fv_2 = feat[slot][4*k+2];
            bank_fv_3 = feat[slot][4*k+3];
        end
        if (slot == NUM_RS_SLOTS - 1) begin
            eos_cycle       = cycle_cnt;            // Fire cycle.
            exp_valid       = 1'b1;
            vertex_buf_idle = 1'b0;
        end
        tick();
        stream_busy = 1'b0;
        bank_sos    = 1'b0;
        bank_eos    = 1'b0;
        batch_held  = (slot == NUM_RS_SLOTS - 1);
    endtask

    task automatic run_batch(input int hold);
        int n;
        exp_valid = 1'b0;
        for (int k = 0; k < NUM_RS_SLOTS; k++) begin
            send_stream(k, batch_len[k], NODE_ID_W'($urandom));
        end
        n = 0;
        while (!result_valid && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!result_valid) begin
            $display("Timed out after %0d cycles waiting for result_valid", n);
            errors++;
        end
        repeat (hold) tick();                       // Downstream buffer busy.
        vertex_buf_idle = 1'b1;
        tick();
        batch_held = 1'b0;
        released   = 1'b1;
        tick();
        released = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h2f8a));
        clk             = 1'b0;
        reset           = 1'b1;
        bank_sos        = 1'b0;
        bank_eos        = 1'b0;
        bank_fv_0       = '0;
        bank_fv_1       = '0;
        bank_fv_2       = '0;
        bank_fv_3       = '0;
        bank_node_id    = '0;
        weight_we       = 1'b0;
        weight_addr     = '0;
        weight_data     = '0;
        vertex_buf_idle = 1'b1;
        exp_valid       = 1'b0;
        after_reset     = 1'b0;
        stream_busy     = 1'b0;
        batch_held      = 1'b0;
        released        = 1'b0;
        eos_cycle       = 0;

        repeat (2) @(posedge clk);
        #10;
        reset       = 1'b0;
        after_reset = 1'b1;
        tick();
        after_reset = 1'b0;
        end_test("reset state");

        write_weights();
        for (int k = 0; k < NUM_RS_SLOTS; k++) begin
            batch_len[k] = 4;
        end
        run_batch(1);
        end_test("full batch");

        for (int k = 0; k < NUM_RS_SLOTS; k++) begin
            batch_len[k] = 2 + (k % 2);             // Slots held full data before.
        end
        run_batch(1);
        end_test("short streams");

        for (int k = 0; k < NUM_RS_SLOTS; k++) begin
            batch_len[k] = $urandom_range(4, 2);
        end
        run_batch($urandom_range(12, 3));
        end_test("vertex buffer back-pressure");

        for (int b = 0; b < 3; b++) begin
            write_weights();
            for (int k = 0; k < NUM_RS_SLOTS; k++) begin
                batch_len[k] = $urandom_range(4, 2);
            end
            run_batch(1);
        end
        end_test("back-to-back batches");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Simulation time limit reached before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/gnn_pkg.sv
logic/vertex_rs.sv
logic/weight_bank.sv
logic/vertex_pe.sv
logic/vertex_pe_array.sv
logic/vertex_update_top.sv
tests/tb_vertex_update.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vertex update testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_vertex_update -f project.f \
    && ./obj_dir/Vtb_vertex_update > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Verilator build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "TESTBENCH FAILED" "$LOG" && { echo "Simulation reported errors"; exit 1; }
exit 0
